//--- common/rsp_ctrl_pkg.sv
package rsp_ctrl_pkg;

  // samples per chirp
  localparam int CHIRP_NUM = 8;
  // chirp position index width
  localparam int IDX_W = 3;

  // twiddles e^(-j*2*pi*k/8), imag over real, q1.23
  // +1.0 clipped to 7fffff, -1.0 kept symmetric at 800001
  localparam logic [rsp_fmt_pkg::TWIDDLE_W-1:0] TWIDDLE_TABLE [CHIRP_NUM] = '{
    48'h000000_7fffff,
    48'ha57d86_5a827a,
    48'h800001_000000,
    48'ha57d86_a57d86,
    48'h000000_800001,
    48'h5a827a_a57d86,
    48'h7fffff_000000,
    48'h5a827a_5a827a
  };

  ////////////////////////////////////////////////////////////
  // result buffer
  ////////////////////////////////////////////////////////////

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW = 4;

endpackage

//--- common/rsp_fmt_pkg.sv
package rsp_fmt_pkg;

  ////////////////////////////////////////////////////////////
  // sample and twiddle formats
  ////////////////////////////////////////////////////////////

  // complex sample word, imag over real
  localparam int SAMPLE_W = 32;
  // one q1.15 component
  localparam int HALF_W = 16;
  // twiddle word, imag over real
  localparam int TWIDDLE_W = 48;
  // one q1.23 component
  localparam int TW_HALF_W = 24;
  // drops the twiddle fraction bits after each product
  localparam int FRAC_SHIFT = 23;

  ////////////////////////////////////////////////////////////
  // pipeline latencies
  ////////////////////////////////////////////////////////////

  localparam int MUL_LAT = 3;
  // operand reg + multiplier + shift stage + final add
  localparam int CPLX_LAT = 6;
  localparam int BYP_LAT = 3;

  typedef logic [SAMPLE_W-1:0] sample_t;

endpackage

//--- common/rsp_sample_if.sv
interface rsp_sample_if;

  // sample with its twiddle, one strobe per sample
  rsp_fmt_pkg::sample_t                x_data;
  logic [rsp_fmt_pkg::TWIDDLE_W-1:0]   w;
  logic                                valid;
  // level, held while samples are in flight
  logic                                bypass;

  modport src (output x_data, output w, output valid, output bypass);
  modport dst (input x_data, input w, input valid, input bypass);

endinterface

//--- design/rsp_prep_buffer.sv
module rsp_prep_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_wr,
  input  rsp_fmt_pkg::sample_t  i_wdata,
  input  logic                  i_pop,
  output rsp_fmt_pkg::sample_t  o_rdata,
  output logic                  o_empty,
  output logic                  o_overflow
);

  rsp_fmt_pkg::sample_t mem [rsp_ctrl_pkg::FIFO_DEPTH];

  // extra msb tells full from empty
  logic [rsp_ctrl_pkg::FIFO_AW:0] wr_ptr;
  logic [rsp_ctrl_pkg::FIFO_AW:0] rd_ptr;
  logic                           full;

  assign o_empty = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr == {~rd_ptr[rsp_ctrl_pkg::FIFO_AW],
                               rd_ptr[rsp_ctrl_pkg::FIFO_AW-1:0]});

  ////////////////////////////////////////////////////////////
  // pointers and sticky overflow
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      o_overflow <= 1'b0;
    end else begin
      // full fifo drops the sample
      if (i_wr && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_wr && full) begin
        o_overflow <= 1'b1;
      end
      if (i_pop && !o_empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage and registered read
  always_ff @(posedge clk) begin
    if (i_wr && !full) begin
      mem[wr_ptr[rsp_ctrl_pkg::FIFO_AW-1:0]] <= i_wdata;
    end
    if (i_pop && !o_empty) begin
      o_rdata <= mem[rd_ptr[rsp_ctrl_pkg::FIFO_AW-1:0]];
    end
  end

  // the frame writer gates its reads with empty
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!rst_n)
    i_pop |-> !o_empty
  );

endmodule

//--- design/rsp_prep_delay.sv
module rsp_prep_delay #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  T     i_d,
  output T     o_q
);

  T pipe [DEPTH];

  // plain shift chain, cleared on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= i_d;
      for (int i = 1; i < DEPTH; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign o_q = pipe[DEPTH-1];

endmodule

//--- design/rsp_prep_frame_writer.sv
module rsp_prep_frame_writer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_rd_en,
  input  logic                  i_empty,
  input  rsp_fmt_pkg::sample_t  i_rdata,
  output logic                  o_pop,
  output rsp_fmt_pkg::sample_t  o_y_data,
  output logic                  o_y_valid,
  output logic                  o_y_last
);

  // output sample position within the chirp
  logic [rsp_ctrl_pkg::IDX_W-1:0] cnt;
  logic                           cnt_end;

  // reads on an empty fifo are dropped
  assign o_pop   = i_rd_en && !i_empty;
  assign cnt_end = (cnt == rsp_ctrl_pkg::IDX_W'(rsp_ctrl_pkg::CHIRP_NUM - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt       <= '0;
      o_y_valid <= 1'b0;
      o_y_last  <= 1'b0;
    end else begin
      // valid and last line up with the registered fifo read
      o_y_valid <= o_pop;
      o_y_last  <= o_pop && cnt_end;
      if (o_pop) begin
        cnt <= cnt_end ? '0 : cnt + 1'b1;
      end
    end
  end

  // fifo read data is already registered
  assign o_y_data = i_rdata;

endmodule

//--- design/rsp_prep_top.sv
module rsp_prep_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_bypass,
  input  logic                  i_chirp_start,
  input  rsp_fmt_pkg::sample_t  i_x_data,
  input  logic                  i_x_valid,
  input  logic                  i_rd_en,
  output rsp_fmt_pkg::sample_t  o_y_data,
  output logic                  o_y_valid,
  output logic                  o_y_last,
  output logic                  o_overflow
);

  // multiplier to buffer
  rsp_fmt_pkg::sample_t y_data;
  logic                 y_valid;
  // buffer to frame writer
  rsp_fmt_pkg::sample_t rd_data;
  logic                 empty;
  logic                 pop;

  rsp_sample_if smp_if ();

  ////////////////////////////////////////////////////////////
  // sequencer -> multiplier -> fifo -> frame writer
  ////////////////////////////////////////////////////////////

  rsp_twiddle_sequencer u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_chirp_start (i_chirp_start),
    .i_x_data      (i_x_data),
    .i_x_valid     (i_x_valid),
    .i_bypass      (i_bypass),
    .o_smp         (smp_if.src)
  );

  rsp_prep_multiplier u_mult (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_smp     (smp_if.dst),
    .o_y_data  (y_data),
    .o_y_valid (y_valid)
  );

  rsp_prep_buffer u_buf (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_wr       (y_valid),
    .i_wdata    (y_data),
    .i_pop      (pop),
    .o_rdata    (rd_data),
    .o_empty    (empty),
    .o_overflow (o_overflow)
  );

  rsp_prep_frame_writer u_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_rd_en   (i_rd_en),
    .i_empty   (empty),
    .i_rdata   (rd_data),
    .o_pop     (pop),
    .o_y_data  (o_y_data),
    .o_y_valid (o_y_valid),
    .o_y_last  (o_y_last)
  );

endmodule

//--- design/rsp_twiddle_sequencer.sv
module rsp_twiddle_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_chirp_start,
  input  rsp_fmt_pkg::sample_t  i_x_data,
  input  logic                  i_x_valid,
  input  logic                  i_bypass,
  rsp_sample_if.src             o_smp
);

  logic [rsp_ctrl_pkg::IDX_W-1:0] idx;
  logic [rsp_ctrl_pkg::IDX_W-1:0] idx_cur;
  logic [rsp_ctrl_pkg::IDX_W-1:0] idx_next;

  // chirp start wins, a sample in the same cycle takes index 0
  assign idx_cur = i_chirp_start ? '0 : idx;
  // wrap at chirp length
  assign idx_next = (idx_cur == rsp_ctrl_pkg::IDX_W'(rsp_ctrl_pkg::CHIRP_NUM - 1)) ?
                    '0 : idx_cur + 1'b1;

  ////////////////////////////////////////////////////////////
  // position counter and control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx          <= '0;
      o_smp.valid  <= 1'b0;
      o_smp.bypass <= 1'b0;
    end else begin
      o_smp.valid  <= i_x_valid;
      o_smp.bypass <= i_bypass;
      // advance only on a sample
      if (i_x_valid) begin
        idx <= idx_next;
      end else begin
        idx <= idx_cur;
      end
    end
  end

  // sample and its twiddle, same stage as valid
  always_ff @(posedge clk) begin
    o_smp.x_data <= i_x_data;
    o_smp.w      <= rsp_ctrl_pkg::TWIDDLE_TABLE[idx_cur];
  end

endmodule

//--- mult/rsp_prep_mult.sv
module rsp_prep_mult #(
  parameter int A_W   = 16,
  parameter int B_W   = 24,
  parameter int DEPTH = rsp_fmt_pkg::MUL_LAT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic signed [A_W-1:0]       i_a,
  input  logic signed [B_W-1:0]       i_b,
  output logic signed [A_W+B_W-1:0]   o_p
);

  // full width product, no rounding here
  logic signed [A_W+B_W-1:0] prod;
  logic signed [A_W+B_W-1:0] pipe [DEPTH];

  assign prod = i_a * i_b;

  // retiming stages behind the multiplier, one product per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= prod;
      for (int i = 1; i < DEPTH; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign o_p = pipe[DEPTH-1];

endmodule

//--- mult/rsp_prep_multiplier.sv
module rsp_prep_multiplier (
  input  logic                  clk,
  input  logic                  rst_n,
  rsp_sample_if.dst             i_smp,
  output rsp_fmt_pkg::sample_t  o_y_data,
  output logic                  o_y_valid
);

  // input components
  logic signed [rsp_fmt_pkg::HALF_W-1:0]      x_re;
  logic signed [rsp_fmt_pkg::HALF_W-1:0]      x_im;
  logic signed [rsp_fmt_pkg::TW_HALF_W-1:0]   w_re;
  logic signed [rsp_fmt_pkg::TW_HALF_W-1:0]   w_im;

  // stage 1 operands, a = x re, b = x im, c = w re, d = w im
  logic signed [rsp_fmt_pkg::HALF_W-1:0]      a_r;
  logic signed [rsp_fmt_pkg::HALF_W-1:0]      b_r;
  logic signed [rsp_fmt_pkg::TW_HALF_W-1:0]   c_r;
  logic signed [rsp_fmt_pkg::TW_HALF_W-1:0]   d_r;
  logic signed [rsp_fmt_pkg::HALF_W:0]        ab_sum;
  logic signed [rsp_fmt_pkg::TW_HALF_W:0]     cd_diff;

  // raw products
  logic signed [rsp_fmt_pkg::HALF_W+rsp_fmt_pkg::TW_HALF_W-1:0] t3;
  logic signed [rsp_fmt_pkg::HALF_W+rsp_fmt_pkg::TW_HALF_W-1:0] t4;
  logic signed [rsp_fmt_pkg::HALF_W+rsp_fmt_pkg::TW_HALF_W+1:0] t5;

  // floor-shifted products, wrapped to 16 bits
  logic [rsp_fmt_pkg::HALF_W-1:0] s_t3;
  logic [rsp_fmt_pkg::HALF_W-1:0] s_t4;
  logic [rsp_fmt_pkg::HALF_W-1:0] s_t5;

  logic [rsp_fmt_pkg::HALF_W-1:0] t5_r;
  logic [rsp_fmt_pkg::HALF_W-1:0] diff_r;
  logic [rsp_fmt_pkg::HALF_W-1:0] imag_r;
  logic [rsp_fmt_pkg::HALF_W-1:0] imag_d;
  logic [rsp_fmt_pkg::HALF_W-1:0] real_r;

  rsp_fmt_pkg::sample_t byp_data;
  logic                 v_cplx;
  logic                 v_byp;
  logic [$clog2(rsp_fmt_pkg::CPLX_LAT+1)-1:0] flight_cnt;

  assign {x_im, x_re} = i_smp.x_data;
  assign {w_im, w_re} = i_smp.w;

  ////////////////////////////////////////////////////////////
  // stage 1, operands and pre-adders
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    a_r     <= x_re;
    b_r     <= x_im;
    c_r     <= w_re;
    d_r     <= w_im;
    ab_sum  <= x_re + x_im;
    cd_diff <= w_re - w_im;
  end

  ////////////////////////////////////////////////////////////
  // stages 2..4, gauss three-multiplier core
  ////////////////////////////////////////////////////////////

  // a*d
  rsp_prep_mult #(
    .A_W   (rsp_fmt_pkg::HALF_W),
    .B_W   (rsp_fmt_pkg::TW_HALF_W),
    .DEPTH (rsp_fmt_pkg::MUL_LAT)
  ) u_t3 (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (a_r),
    .i_b   (d_r),
    .o_p   (t3)
  );

  // b*c
  rsp_prep_mult #(
    .A_W   (rsp_fmt_pkg::HALF_W),
    .B_W   (rsp_fmt_pkg::TW_HALF_W),
    .DEPTH (rsp_fmt_pkg::MUL_LAT)
  ) u_t4 (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (b_r),
    .i_b   (c_r),
    .o_p   (t4)
  );

  // (a+b)*(c-d), one bit wider on each side
  rsp_prep_mult #(
    .A_W   (rsp_fmt_pkg::HALF_W + 1),
    .B_W   (rsp_fmt_pkg::TW_HALF_W + 1),
    .DEPTH (rsp_fmt_pkg::MUL_LAT)
  ) u_t5 (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (ab_sum),
    .i_b   (cd_diff),
    .o_p   (t5)
  );

  // slicing above the fraction is floor shift plus wrap
  assign s_t3 = t3[rsp_fmt_pkg::FRAC_SHIFT+rsp_fmt_pkg::HALF_W-1:rsp_fmt_pkg::FRAC_SHIFT];
  assign s_t4 = t4[rsp_fmt_pkg::FRAC_SHIFT+rsp_fmt_pkg::HALF_W-1:rsp_fmt_pkg::FRAC_SHIFT];
  assign s_t5 = t5[rsp_fmt_pkg::FRAC_SHIFT+rsp_fmt_pkg::HALF_W-1:rsp_fmt_pkg::FRAC_SHIFT];

  ////////////////////////////////////////////////////////////
  // stages 5..6, post-adders
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // stage 5
    t5_r   <= s_t5;
    diff_r <= s_t3 - s_t4;
    imag_r <= s_t3 + s_t4;
    // stage 6, real = t5 + t3 - t4
    real_r <= t5_r + diff_r;
  end

  // imag is ready a stage early, align it with real
  rsp_prep_delay #(
    .T     (logic [rsp_fmt_pkg::HALF_W-1:0]),
    .DEPTH (1)
  ) u_imag_align (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (imag_r),
    .o_q   (imag_d)
  );

  ////////////////////////////////////////////////////////////
  // bypass path and strobes
  ////////////////////////////////////////////////////////////

  rsp_prep_delay #(
    .T     (rsp_fmt_pkg::sample_t),
    .DEPTH (rsp_fmt_pkg::BYP_LAT)
  ) u_byp_data (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (i_smp.x_data),
    .o_q   (byp_data)
  );

  rsp_prep_delay #(
    .T     (logic),
    .DEPTH (rsp_fmt_pkg::CPLX_LAT)
  ) u_cplx_valid (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (i_smp.valid),
    .o_q   (v_cplx)
  );

  rsp_prep_delay #(
    .T     (logic),
    .DEPTH (rsp_fmt_pkg::BYP_LAT)
  ) u_byp_valid (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (i_smp.valid),
    .o_q   (v_byp)
  );

  // mode is static while anything is in flight
  assign o_y_valid = i_smp.bypass ? v_byp : v_cplx;
  assign o_y_data  = i_smp.bypass ? byp_data : {imag_d, real_r};

  // cycles left until the newest sample has left the pipe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flight_cnt <= '0;
    end else if (i_smp.valid) begin
      flight_cnt <= $bits(flight_cnt)'(rsp_fmt_pkg::CPLX_LAT);
    end else if (flight_cnt != '0) begin
      flight_cnt <= flight_cnt - 1'b1;
    end
  end

  // mode change with samples in flight would mix the two paths
  a_bypass_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (flight_cnt != '0) |-> $stable(i_smp.bypass)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_rsp_prep -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_rsp_prep > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi
cat "$LOG"

if grep -qx "TEST PASS" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- src.f
common/rsp_fmt_pkg.sv
common/rsp_ctrl_pkg.sv
common/rsp_sample_if.sv
mult/rsp_prep_mult.sv
design/rsp_prep_delay.sv
mult/rsp_prep_multiplier.sv
design/rsp_twiddle_sequencer.sv
design/rsp_prep_buffer.sv
design/rsp_prep_frame_writer.sv
design/rsp_prep_top.sv
tb/tb_rsp_prep.sv

//--- tb/tb_rsp_prep.sv
module tb_rsp_prep;
  timeunit 1ns;
  timeprecision 1ps;

  logic                 clk;
  logic                 rst_n;
  logic                 i_bypass;
  logic                 i_chirp_start;
  rsp_fmt_pkg::sample_t i_x_data;
  logic                 i_x_valid;
  logic                 i_rd_en;
  rsp_fmt_pkg::sample_t o_y_data;
  logic                 o_y_valid;
  logic                 o_y_last;
  logic                 o_overflow;

  int                   err_cnt;
  // model chirp position and output sample count
  int                   pos;
  int                   out_cnt;
  rsp_fmt_pkg::sample_t exp_q [$];

  rsp_prep_top i_rsp_prep_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_bypass      (i_bypass),
    .i_chirp_start (i_chirp_start),
    .i_x_data      (i_x_data),
    .i_x_valid     (i_x_valid),
    .i_rd_en       (i_rd_en),
    .o_y_data      (o_y_data),
    .o_y_valid     (o_y_valid),
    .o_y_last      (o_y_last),
    .o_overflow    (o_overflow)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // model and helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // gauss product, each term floor-shifted, sums wrapped to 16 bits
  task automatic model_product(input logic [31:0] x, input logic [47:0] w,
                               output logic [31:0] y);
    longint      a;
    longint      b;
    longint      c;
    longint      d;
    longint      t3;
    longint      t4;
    longint      t5;
    logic [15:0] re;
    logic [15:0] im;
    a  = longint'($signed(x[15:0]));
    b  = longint'($signed(x[31:16]));
    c  = longint'($signed(w[23:0]));
    d  = longint'($signed(w[47:24]));
    t3 = (a * d) >>> rsp_fmt_pkg::FRAC_SHIFT;
    t4 = (b * c) >>> rsp_fmt_pkg::FRAC_SHIFT;
    t5 = ((a + b) * (c - d)) >>> rsp_fmt_pkg::FRAC_SHIFT;
    re = 16'(t5 + t3 - t4);
    im = 16'(t3 + t4);
    y  = {im, re};
  endtask

  task automatic pulse_chirp_start();
    i_chirp_start = 1'b1;
    @(posedge clk);
    #2;
    i_chirp_start = 1'b0;
    pos = 0;
  endtask

  // one strobe, expected word queued unless the fifo will drop it
  task automatic send_sample(input rsp_fmt_pkg::sample_t x, input bit keep);
    rsp_fmt_pkg::sample_t y;
    if (i_bypass) begin
      y = x;
    end else begin
      model_product(x, rsp_ctrl_pkg::TWIDDLE_TABLE[pos], y);
    end
    if (keep) begin
      exp_q.push_back(y);
    end
    // position advances in both modes
    pos = (pos + 1) % rsp_ctrl_pkg::CHIRP_NUM;
    i_x_data  = x;
    i_x_valid = 1'b1;
    @(posedge clk);
    #2;
    i_x_valid = 1'b0;
  endtask

  // retry read strobes until one is accepted
  task automatic read_word(output rsp_fmt_pkg::sample_t data, output logic last,
                           output bit ok);
    int tries;
    tries = 0;
    ok    = 1'b0;
    data  = '0;
    last  = 1'b0;
    while (!ok && tries < 40) begin
      i_rd_en = 1'b1;
      @(posedge clk);
      #2;
      i_rd_en = 1'b0;
      if (o_y_valid) begin
        data = o_y_data;
        last = o_y_last;
        ok   = 1'b1;
      end else begin
        @(posedge clk);
        #2;
        tries++;
      end
    end
    if (!ok) begin
      $display("timeout at %0d ns: no read data came out of the FIFO", $time);
      err_cnt++;
    end
  endtask

  task automatic read_and_check(input int n);
    rsp_fmt_pkg::sample_t data;
    logic                 last;
    bit                   ok;
    for (int i = 0; i < n; i++) begin
      read_word(data, last, ok);
      if (ok && exp_q.size() == 0) begin
        $display("read returned a word that was never expected");
        err_cnt++;
      end else if (ok) begin
        check_value("o_y_data", data, exp_q.pop_front());
        // last on every eighth output
        check_value("o_y_last", last,
                    32'(out_cnt % rsp_ctrl_pkg::CHIRP_NUM == rsp_ctrl_pkg::CHIRP_NUM - 1));
        out_cnt++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    repeat (10) begin
      @(posedge clk);
      #2;
      check_value("o_y_valid", o_y_valid, 0);
      check_value("o_y_last", o_y_last, 0);
      check_value("o_overflow", o_overflow, 0);
    end
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    check_value("o_y_valid", o_y_valid, 0);
    check_value("o_y_last", o_y_last, 0);
    check_value("o_overflow", o_overflow, 0);
  endtask

  task automatic test_complex();
    pulse_chirp_start();
    for (int i = 0; i < 8; i++) begin
      send_sample($urandom(), 1'b1);
    end
    read_and_check(8);
  endtask

  // restart mid chirp, the next eight use indices 0..7
  task automatic test_restart();
    for (int i = 0; i < 5; i++) begin
      send_sample($urandom(), 1'b1);
    end
    pulse_chirp_start();
    for (int i = 0; i < 8; i++) begin
      send_sample($urandom(), 1'b1);
    end
    read_and_check(13);
  endtask

  task automatic test_bypass();
    // pipe is drained here, mode change is safe
    i_bypass = 1'b1;
    repeat (2) begin
      @(posedge clk);
      #2;
    end
    for (int i = 0; i < 8; i++) begin
      send_sample($urandom(), 1'b1);
    end
    read_and_check(8);
    i_bypass = 1'b0;
    repeat (2) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic test_overflow();
    int tries;
    // last four are dropped by the full fifo
    for (int i = 0; i < 20; i++) begin
      send_sample($urandom(), i < rsp_ctrl_pkg::FIFO_DEPTH);
    end
    tries = 0;
    while (!o_overflow && tries < 20) begin
      @(posedge clk);
      #2;
      tries++;
    end
    if (!o_overflow) begin
      $display("timeout at %0d ns: overflow flag never rose", $time);
      err_cnt++;
    end
    // the later dropped samples still reach the full fifo, one per cycle
    repeat (20 - rsp_ctrl_pkg::FIFO_DEPTH - 1) begin
      @(posedge clk);
      #2;
    end
    read_and_check(rsp_ctrl_pkg::FIFO_DEPTH);
  endtask

  task automatic test_empty_read();
    i_rd_en = 1'b1;
    @(posedge clk);
    #2;
    i_rd_en = 1'b0;
    repeat (3) begin
      check_value("o_y_valid", o_y_valid, 0);
      // sticky since the overflow test
      check_value("o_overflow", o_overflow, 1);
      @(posedge clk);
      #2;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    i_bypass      = 1'b0;
    i_chirp_start = 1'b0;
    i_x_data      = '0;
    i_x_valid     = 1'b0;
    i_rd_en       = 1'b0;
    err_cnt       = 0;
    pos           = 0;
    out_cnt       = 0;
    void'($urandom(32'ha653));

    test_reset();
    test_complex();
    test_restart();
    test_bypass();
    test_overflow();
    test_empty_read();

    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
